/* logic/spu_pkg.sv */
`default_nettype none

package spu_pkg;

  localparam int reg_w = 7;
  localparam int imm_w = 10;
  localparam int id_w  = 3;

  // instruction ids carried to the slots
  localparam logic [id_w-1:0] id_nop    = 3'd0;
  localparam logic [id_w-1:0] id_lnop   = 3'd1;
  localparam logic [id_w-1:0] id_add    = 3'd2;
  localparam logic [id_w-1:0] id_addi   = 3'd3;
  localparam logic [id_w-1:0] id_lqd    = 3'd4;
  localparam logic [id_w-1:0] id_rotqby = 3'd5;

  localparam logic [10:0] op_a      = 11'b00011000000;
  localparam logic [10:0] op_rotqby = 11'b00111011100;
  localparam logic [10:0] op_nop    = 11'b01000000001; // even pipe nop
  localparam logic [10:0] op_lnop   = 11'b00000000001; // odd pipe nop
  localparam logic [7:0]  op_ai     = 8'b00011100;
  localparam logic [7:0]  op_lqd    = 8'b00110100;

  localparam logic pipe_even = 1'b0;
  localparam logic pipe_odd  = 1'b1;

  localparam logic [1:0] sel_none   = 2'd0;
  localparam logic [1:0] sel_first  = 2'd1;
  localparam logic [1:0] sel_second = 2'd2;

  // same 32 bits seen as RR or RI10 form
  typedef union packed {
    struct packed {
      logic [10:0]      op;
      logic [reg_w-1:0] rb;
      logic [reg_w-1:0] ra;
      logic [reg_w-1:0] rt;
    } rr;
    struct packed {
      logic [7:0]       op;
      logic [imm_w-1:0] imm;
      logic [reg_w-1:0] ra;
      logic [reg_w-1:0] rt;
    } ri10;
  } instr_word_u;

endpackage

`default_nettype wire

/* logic/decoded_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface decoded_if;

  logic                      pipe;     // pipe_even or pipe_odd
  logic [spu_pkg::id_w-1:0]  instr_id;
  logic [spu_pkg::reg_w-1:0] reg_dst;
  logic                      reg_wr;
  logic [spu_pkg::reg_w-1:0] ra;
  logic [spu_pkg::reg_w-1:0] rb;
  logic                      uses_rb;  // rb is a real source
  logic [spu_pkg::imm_w-1:0] imm;

  modport src (
    output pipe, instr_id, reg_dst, reg_wr,
    output ra, rb, uses_rb, imm
  );

  modport snk (
    input pipe, instr_id, reg_dst, reg_wr,
    input ra, rb, uses_rb, imm
  );

endinterface

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  logic [31:0]   word,
  decoded_if.src        dec
);

  spu_pkg::instr_word_u w;

  assign w = word;

  always_comb begin
    // unknown words fall through as an even nop
    dec.pipe     = spu_pkg::pipe_even;
    dec.instr_id = spu_pkg::id_nop;
    dec.reg_dst  = '0;
    dec.reg_wr   = 1'b0;
    dec.ra       = '0;
    dec.rb       = '0;
    dec.uses_rb  = 1'b0;
    dec.imm      = '0;

    case (w.rr.op)
      spu_pkg::op_a, spu_pkg::op_rotqby: begin
        dec.pipe     = (w.rr.op == spu_pkg::op_a) ? spu_pkg::pipe_even : spu_pkg::pipe_odd;
        dec.instr_id = (w.rr.op == spu_pkg::op_a) ? spu_pkg::id_add : spu_pkg::id_rotqby;
        dec.reg_dst  = w.rr.rt;
        dec.reg_wr   = 1'b1;
        dec.ra       = w.rr.ra;
        dec.rb       = w.rr.rb;
        dec.uses_rb  = 1'b1;
      end
      spu_pkg::op_nop: begin
        dec.instr_id = spu_pkg::id_nop;
      end
      spu_pkg::op_lnop: begin
        dec.pipe     = spu_pkg::pipe_odd;
        dec.instr_id = spu_pkg::id_lnop;
      end
      default: begin
        // no 11-bit match, try the RI10 opcodes
        case (w.ri10.op)
          spu_pkg::op_ai: begin
            dec.instr_id = spu_pkg::id_addi;
            dec.reg_dst  = w.ri10.rt;
            dec.reg_wr   = 1'b1;
            dec.ra       = w.ri10.ra;
            dec.imm      = w.ri10.imm;
          end
          spu_pkg::op_lqd: begin
            dec.pipe     = spu_pkg::pipe_odd;
            dec.instr_id = spu_pkg::id_lqd;
            dec.reg_dst  = w.ri10.rt;
            dec.reg_wr   = 1'b1;
            dec.ra       = w.ri10.ra; // base address register
            dec.imm      = w.ri10.imm;
          end
          default: ;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/pair_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pair_checker (
  decoded_if.snk first,
  decoded_if.snk second,
  output logic   split_req
);

  logic same_pipe;
  logic second_reads;
  logic raw_ra;
  logic raw_rb;

  assign same_pipe = (first.pipe == second.pipe);

  // nop and lnop have no sources
  assign second_reads = (second.instr_id != spu_pkg::id_nop) &&
                        (second.instr_id != spu_pkg::id_lnop);

  assign raw_ra = first.reg_wr && second_reads && (first.reg_dst == second.ra);
  assign raw_rb = first.reg_wr && second.uses_rb && (first.reg_dst == second.rb);

  assign split_req = same_pipe || raw_ra || raw_rb;

endmodule

`default_nettype wire

/* logic/issue_control.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_control (
  input  logic       clk,
  input  logic       rst,
  input  logic       branch_taken,
  input  logic       split_req,
  input  logic       first_pipe,
  input  logic       second_pipe,
  output logic       stall,
  output logic       flush,
  output logic       clear_slots,
  output logic [1:0] even_sel,
  output logic [1:0] odd_sel
);

  logic second_half; // held pair, second instruction goes now

  assign stall       = split_req && !second_half && !branch_taken;
  assign clear_slots = branch_taken;

  // second_half lasts exactly the cycle after a stall
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      second_half <= 1'b0;
      flush       <= 1'b0;
    end else begin
      second_half <= stall;
      flush       <= branch_taken;
    end
  end

  always_comb begin
    even_sel = spu_pkg::sel_none;
    odd_sel  = spu_pkg::sel_none;
    if (second_half) begin
      if (second_pipe == spu_pkg::pipe_even) even_sel = spu_pkg::sel_second;
      else odd_sel = spu_pkg::sel_second;
    end else if (split_req) begin
      // first half of a split, other slot stays empty
      if (first_pipe == spu_pkg::pipe_even) even_sel = spu_pkg::sel_first;
      else odd_sel = spu_pkg::sel_first;
    end else begin
      if (first_pipe == spu_pkg::pipe_even) even_sel = spu_pkg::sel_first;
      else odd_sel = spu_pkg::sel_first;
      if (second_pipe == spu_pkg::pipe_even) even_sel = spu_pkg::sel_second;
      else odd_sel = spu_pkg::sel_second;
    end
  end

endmodule

`default_nettype wire

/* logic/slot_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module slot_regs (
  input  logic                      clk,
  input  logic                      rst,
  decoded_if.snk                    first,
  decoded_if.snk                    second,
  input  logic [1:0]                even_sel,
  input  logic [1:0]                odd_sel,
  input  logic                      clear_slots,
  output logic [spu_pkg::id_w-1:0]  even_instr_id,
  output logic [spu_pkg::reg_w-1:0] even_reg_dst,
  output logic                      even_reg_wr,
  output logic [spu_pkg::reg_w-1:0] even_ra,
  output logic [spu_pkg::reg_w-1:0] even_rb,
  output logic [spu_pkg::imm_w-1:0] even_imm,
  output logic [spu_pkg::id_w-1:0]  odd_instr_id,
  output logic [spu_pkg::reg_w-1:0] odd_reg_dst,
  output logic                      odd_reg_wr,
  output logic [spu_pkg::reg_w-1:0] odd_ra,
  output logic [spu_pkg::reg_w-1:0] odd_rb,
  output logic [spu_pkg::imm_w-1:0] odd_imm
);

  // index 0 is the even slot, 1 the odd slot
  logic [spu_pkg::id_w-1:0]  slot_id  [2];
  logic [spu_pkg::reg_w-1:0] slot_dst [2];
  logic                      slot_wr  [2];
  logic [spu_pkg::reg_w-1:0] slot_ra  [2];
  logic [spu_pkg::reg_w-1:0] slot_rb  [2];
  logic [spu_pkg::imm_w-1:0] slot_imm [2];

  for (genvar p = 0; p < 2; p++) begin : g_slot
    localparam logic [spu_pkg::id_w-1:0] fill_id = (p == 0) ? spu_pkg::id_nop : spu_pkg::id_lnop;

    logic [1:0]                sel;
    logic [spu_pkg::id_w-1:0]  id_q;
    logic [spu_pkg::reg_w-1:0] dst_q;
    logic                      wr_q;
    logic [spu_pkg::reg_w-1:0] ra_q;
    logic [spu_pkg::reg_w-1:0] rb_q;
    logic [spu_pkg::imm_w-1:0] imm_q;

    assign sel = (p == 0) ? even_sel : odd_sel;

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        id_q  <= fill_id;
        dst_q <= '0;
        wr_q  <= 1'b0;
        ra_q  <= '0;
        rb_q  <= '0;
        imm_q <= '0;
      end else if (clear_slots || sel == spu_pkg::sel_none) begin
        id_q  <= fill_id; // empty slot gets its pipe's nop
        dst_q <= '0;
        wr_q  <= 1'b0;
        ra_q  <= '0;
        rb_q  <= '0;
        imm_q <= '0;
      end else if (sel == spu_pkg::sel_first) begin
        id_q  <= first.instr_id;
        dst_q <= first.reg_dst;
        wr_q  <= first.reg_wr;
        ra_q  <= first.ra;
        rb_q  <= first.rb;
        imm_q <= first.imm;
      end else begin
        id_q  <= second.instr_id;
        dst_q <= second.reg_dst;
        wr_q  <= second.reg_wr;
        ra_q  <= second.ra;
        rb_q  <= second.rb;
        imm_q <= second.imm;
      end
    end

    assign slot_id[p]  = id_q;
    assign slot_dst[p] = dst_q;
    assign slot_wr[p]  = wr_q;
    assign slot_ra[p]  = ra_q;
    assign slot_rb[p]  = rb_q;
    assign slot_imm[p] = imm_q;
  end

  assign even_instr_id = slot_id[0];
  assign even_reg_dst  = slot_dst[0];
  assign even_reg_wr   = slot_wr[0];
  assign even_ra       = slot_ra[0];
  assign even_rb       = slot_rb[0];
  assign even_imm      = slot_imm[0];
  assign odd_instr_id  = slot_id[1];
  assign odd_reg_dst   = slot_dst[1];
  assign odd_reg_wr    = slot_wr[1];
  assign odd_ra        = slot_ra[1];
  assign odd_rb        = slot_rb[1];
  assign odd_imm       = slot_imm[1];

endmodule

`default_nettype wire

/* logic/spu_issue_top.sv */
`timescale 1ns/1ns
`default_nettype none

module spu_issue_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [31:0]               instr_in1,
  input  logic [31:0]               instr_in2,
  input  logic                      branch_taken,
  output logic                      stall,
  output logic                      flush,
  output logic [spu_pkg::id_w-1:0]  even_instr_id,
  output logic [spu_pkg::reg_w-1:0] even_reg_dst,
  output logic                      even_reg_wr,
  output logic [spu_pkg::reg_w-1:0] even_ra,
  output logic [spu_pkg::reg_w-1:0] even_rb,
  output logic [spu_pkg::imm_w-1:0] even_imm,
  output logic [spu_pkg::id_w-1:0]  odd_instr_id,
  output logic [spu_pkg::reg_w-1:0] odd_reg_dst,
  output logic                      odd_reg_wr,
  output logic [spu_pkg::reg_w-1:0] odd_ra,
  output logic [spu_pkg::reg_w-1:0] odd_rb,
  output logic [spu_pkg::imm_w-1:0] odd_imm
);

  decoded_if dec1_bus ();
  decoded_if dec2_bus ();

  logic       split_req;
  logic       clear_slots;
  logic [1:0] even_sel;
  logic [1:0] odd_sel;

  instr_decoder u_dec1 (.word(instr_in1), .dec(dec1_bus.src));
  instr_decoder u_dec2 (.word(instr_in2), .dec(dec2_bus.src));

  pair_checker u_pair (
    .first     (dec1_bus.snk),
    .second    (dec2_bus.snk),
    .split_req (split_req)
  );

  issue_control u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .branch_taken (branch_taken),
    .split_req    (split_req),
    .first_pipe   (dec1_bus.pipe),
    .second_pipe  (dec2_bus.pipe),
    .stall        (stall),
    .flush        (flush),
    .clear_slots  (clear_slots),
    .even_sel     (even_sel),
    .odd_sel      (odd_sel)
  );

  slot_regs u_slots (
    .clk           (clk),
    .rst           (rst),
    .first         (dec1_bus.snk),
    .second        (dec2_bus.snk),
    .even_sel      (even_sel),
    .odd_sel       (odd_sel),
    .clear_slots   (clear_slots),
    .even_instr_id (even_instr_id),
    .even_reg_dst  (even_reg_dst),
    .even_reg_wr   (even_reg_wr),
    .even_ra       (even_ra),
    .even_rb       (even_rb),
    .even_imm      (even_imm),
    .odd_instr_id  (odd_instr_id),
    .odd_reg_dst   (odd_reg_dst),
    .odd_reg_wr    (odd_reg_wr),
    .odd_ra        (odd_ra),
    .odd_rb        (odd_rb),
    .odd_imm       (odd_imm)
  );

endmodule

`default_nettype wire

/* verif/issue_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_checker (
  input logic                      clk,
  input logic                      rst,
  input logic [31:0]               instr_in1,
  input logic [31:0]               instr_in2,
  input logic                      branch_taken,
  input logic                      stall,
  input logic                      flush,
  input logic [spu_pkg::id_w-1:0]  even_instr_id, odd_instr_id,
  input logic [spu_pkg::reg_w-1:0] even_reg_dst, even_ra, even_rb,
  input logic [spu_pkg::reg_w-1:0] odd_reg_dst, odd_ra, odd_rb,
  input logic                      even_reg_wr, odd_reg_wr,
  input logic [spu_pkg::imm_w-1:0] even_imm, odd_imm
);

  typedef struct packed {
    logic [spu_pkg::id_w-1:0]  id;
    logic [spu_pkg::reg_w-1:0] dst;
    logic                      wr;
    logic [spu_pkg::reg_w-1:0] ra;
    logic [spu_pkg::reg_w-1:0] rb;
    logic [spu_pkg::imm_w-1:0] imm;
  } slot_t;

  typedef struct packed {
    logic  pipe;
    logic  rd_ra;
    logic  rd_rb;
    slot_t s;
  } dec_t;

  dec_t  d1, d2;
  slot_t even_slot, odd_slot, exp_even, exp_odd;
  logic  split, half2, exp_flush;
  int    err_cnt = 0;

  // expected decode straight from the RR and RI10 bit fields
  function automatic dec_t decode(input logic [31:0] w);
    dec_t d;
    d = '0;
    if (w[31:21] == spu_pkg::op_a || w[31:21] == spu_pkg::op_rotqby) begin
      d.pipe  = (w[31:21] == spu_pkg::op_rotqby);
      d.s.id  = d.pipe ? spu_pkg::id_rotqby : spu_pkg::id_add;
      d.s.rb  = w[20:14];
      d.rd_rb = 1'b1;
    end else if (w[31:21] == spu_pkg::op_lnop) begin
      d.pipe = 1'b1;
      d.s.id = spu_pkg::id_lnop;
    end else if (w[31:24] == spu_pkg::op_ai || w[31:24] == spu_pkg::op_lqd) begin
      d.pipe  = (w[31:24] == spu_pkg::op_lqd);
      d.s.id  = d.pipe ? spu_pkg::id_lqd : spu_pkg::id_addi;
      d.s.imm = w[23:14];
    end
    if (d.s.id != spu_pkg::id_nop && d.s.id != spu_pkg::id_lnop) begin
      d.s.dst = w[6:0];
      d.s.wr  = 1'b1;
      d.s.ra  = w[13:7];
      d.rd_ra = 1'b1;
    end
    return d;
  endfunction

  function automatic slot_t fill(input logic odd);
    slot_t s;
    s = '0;
    s.id = odd ? spu_pkg::id_lnop : spu_pkg::id_nop;
    return s;
  endfunction

  assign d1 = decode(instr_in1);
  assign d2 = decode(instr_in2);
  assign even_slot = {even_instr_id, even_reg_dst, even_reg_wr, even_ra, even_rb, even_imm};
  assign odd_slot  = {odd_instr_id, odd_reg_dst, odd_reg_wr, odd_ra, odd_rb, odd_imm};

  assign split = (d1.pipe == d2.pipe) || (d1.s.wr &&
                 ((d2.rd_ra && d1.s.dst == d2.s.ra) || (d2.rd_rb && d1.s.dst == d2.s.rb)));

  // reference issue model where later assignments win
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      half2     <= 1'b0;
      exp_flush <= 1'b0;
      exp_even  <= fill(1'b0);
      exp_odd   <= fill(1'b1);
    end else begin
      half2     <= split && !half2 && !branch_taken;
      exp_flush <= branch_taken;
      exp_even  <= fill(1'b0);
      exp_odd   <= fill(1'b1);
      if (!branch_taken) begin
        if (!half2 && !d1.pipe) exp_even <= d1.s;
        if (!half2 && d1.pipe) exp_odd <= d1.s;
        if ((half2 || !split) && !d2.pipe) exp_even <= d2.s;
        if ((half2 || !split) && d2.pipe) exp_odd <= d2.s;
      end
    end
  end

  a_reset_ctrl: assert property (@(posedge clk) rst |-> !stall)
    else begin
      err_cnt++;
      $error("FAILED at %0t: stall high during reset", $time);
    end
  a_reset_slots: assert property (@(posedge clk)
    rst |=> !flush && even_slot == fill(1'b0) && odd_slot == fill(1'b1))
    else begin
      err_cnt++;
      $error("FAILED at %0t: slots not nop/lnop after reset", $time);
    end
  a_even_slot: assert property (@(posedge clk) disable iff (rst) even_slot == exp_even)
    else begin
      err_cnt++;
      $error("FAILED at %0t: even slot %h, expected %h", $time, even_slot, exp_even);
    end
  a_odd_slot: assert property (@(posedge clk) disable iff (rst) odd_slot == exp_odd)
    else begin
      err_cnt++;
      $error("FAILED at %0t: odd slot %h, expected %h", $time, odd_slot, exp_odd);
    end
  a_stall: assert property (@(posedge clk) disable iff (rst)
    stall == (split && !half2 && !branch_taken))
    else begin
      err_cnt++;
      $error("FAILED at %0t: stall is %b", $time, stall);
    end
  a_flush: assert property (@(posedge clk) disable iff (rst) flush == exp_flush)
    else begin
      err_cnt++;
      $error("FAILED at %0t: flush is %b", $time, flush);
    end
  a_flush_clears: assert property (@(posedge clk) disable iff (rst)
    flush |-> even_slot == fill(1'b0) && odd_slot == fill(1'b1))
    else begin
      err_cnt++;
      $error("FAILED at %0t: slots not cleared on flush", $time);
    end

endmodule

bind spu_issue_top issue_checker u_issue_chk (.*);

`default_nettype wire

/* verif/tb_spu_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_spu_issue;

  localparam int n_random = 200;
  // three cycles per pair covers a split, plus reset and slack
  localparam int timeout_ns = (n_random + 20) * 3 * 100 + 16 * 100 + 5000;

  logic                      clk = 1'b0;
  logic                      rst;
  logic [31:0]               instr_in1, instr_in2;
  logic                      branch_taken;
  logic                      stall, flush;
  logic [spu_pkg::id_w-1:0]  even_instr_id, odd_instr_id;
  logic [spu_pkg::reg_w-1:0] even_reg_dst, even_ra, even_rb;
  logic [spu_pkg::reg_w-1:0] odd_reg_dst, odd_ra, odd_rb;
  logic                      even_reg_wr, odd_reg_wr;
  logic [spu_pkg::imm_w-1:0] even_imm, odd_imm;
  logic                      stall_seen;
  logic [31:0]               words [8];
  int                        seed;

  spu_issue_top spu_issue_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) stall_seen <= stall; // value just before the edge

  always @(negedge clk) begin
    if (spu_issue_top_i.u_issue_chk.err_cnt != 0) begin
      $display("Checks failed");
      $fatal(1, "an assertion in the checker failed, stopping the run");
    end
  end

  initial begin
    #(timeout_ns);
    $display("Checks failed");
    $fatal(1, "the run timed out before all pairs were issued");
  end

  function automatic logic [31:0] rr_word(input logic [10:0] op, input int rb, ra, rt);
    return {op, rb[6:0], ra[6:0], rt[6:0]};
  endfunction

  function automatic logic [31:0] ri10_word(input logic [7:0] op, input int imm, ra, rt);
    return {op, imm[9:0], ra[6:0], rt[6:0]};
  endfunction

  // called on a falling edge, returns on one
  task automatic send_pair(input logic [31:0] w1, input logic [31:0] w2, input logic br);
    instr_in1 = w1;
    instr_in2 = w2;
    branch_taken = br;
    @(negedge clk);
    branch_taken = 1'b0;
    if (stall_seen) @(negedge clk); // hold for the second half
  endtask

  task automatic flush_split(input logic [31:0] w1, input logic [31:0] w2);
    instr_in1 = w1;
    instr_in2 = w2;
    @(negedge clk);
    branch_taken = 1'b1; // lands on the second half
    @(negedge clk);
    branch_taken = 1'b0;
    instr_in1 = words[2];
    instr_in2 = words[3];
    @(negedge clk);
  endtask

  task automatic run_directed();
    send_pair(rr_word(spu_pkg::op_a, 2, 1, 3), ri10_word(spu_pkg::op_lqd, 'h040, 4, 10), 1'b0);
    send_pair(ri10_word(spu_pkg::op_lqd, 'h3f0, 6, 7), ri10_word(spu_pkg::op_ai, 'h155, 8, 9), 1'b0);
    // same pipe, even then odd
    send_pair(rr_word(spu_pkg::op_a, 2, 1, 3), ri10_word(spu_pkg::op_ai, 'h011, 4, 5), 1'b0);
    send_pair(rr_word(spu_pkg::op_rotqby, 9, 8, 7), ri10_word(spu_pkg::op_lqd, 'h2a, 1, 2), 1'b0);
    // dependency through ra, then through rb
    send_pair(ri10_word(spu_pkg::op_ai, 'h001, 1, 5), rr_word(spu_pkg::op_rotqby, 2, 5, 6), 1'b0);
    send_pair(rr_word(spu_pkg::op_a, 1, 2, 6), rr_word(spu_pkg::op_rotqby, 6, 3, 7), 1'b0);
    send_pair(rr_word(spu_pkg::op_a, 2, 1, 3), ri10_word(spu_pkg::op_lqd, 'h100, 4, 11), 1'b1);
    send_pair(rr_word(spu_pkg::op_a, 2, 1, 3), ri10_word(spu_pkg::op_ai, 'h0f0, 3, 4), 1'b1);
    flush_split(rr_word(spu_pkg::op_a, 2, 1, 3), ri10_word(spu_pkg::op_ai, 'h011, 4, 5));
  endtask

  task automatic run_random();
    int  i1;
    int  i2;
    logic br;
    for (int n = 0; n < n_random; n++) begin
      i1 = {$random(seed)} % 8;
      i2 = {$random(seed)} % 8;
      br = ({$random(seed)} % 16) == 0;
      send_pair(words[i1], words[i2], br);
    end
  endtask

  initial begin
    seed = 22;
    rst = 1'b1;
    branch_taken = 1'b0;
    words[0] = rr_word(spu_pkg::op_a, 2, 1, 3);
    words[1] = rr_word(spu_pkg::op_rotqby, 3, 4, 5);
    words[2] = {spu_pkg::op_nop, 21'd0};
    words[3] = {spu_pkg::op_lnop, 21'd0};
    words[4] = ri10_word(spu_pkg::op_ai, 'h015, 3, 1);
    words[5] = ri10_word(spu_pkg::op_lqd, 'h3ff, 5, 2);
    words[6] = rr_word(spu_pkg::op_a, 5, 2, 4);
    words[7] = 32'hdead_beef; // no opcode match
    instr_in1 = words[2];
    instr_in2 = words[3];
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    run_directed();
    run_random();
    instr_in1 = words[2];
    instr_in2 = words[3];
    repeat (3) @(negedge clk);
    if (spu_issue_top_i.u_issue_chk.err_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "assertion errors were counted by the end of the run");
    end
  end

endmodule

`default_nettype wire

/* sim.f */
logic/spu_pkg.sv
logic/decoded_if.sv
logic/instr_decoder.sv
logic/pair_checker.sv
logic/issue_control.sv
logic/slot_regs.sv
logic/spu_issue_top.sv
verif/issue_checker.sv
verif/tb_spu_issue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_spu_issue \
  -Mdir obj_dir -o sim_bin \
  && ./obj_dir/sim_bin > sim.log 2>&1 \
  || { echo "simulation build or run failed"; cat sim.log 2>/dev/null; exit 1; }
grep -q "^All checks passed$" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
